// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int NUM_REGS = 32;

  typedef logic [15:0] word_t;    // memory, register and immediate width
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  run_len_t; // register count minus one

  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,
    OP_JMP_PLUS  = 8'd5,
    OP_JMP_MINUS = 8'd7,
    OP_RAM2REG   = 8'd9,
    OP_REG2RAM   = 8'd14,
    OP_NUM2REG   = 8'd18,
    OP_REG_PLUS  = 8'd19,
    OP_REG_MINUS = 8'd20,
    OP_REG_MUL   = 8'd21,
    OP_REG_DIV   = 8'd22
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_SET,
    ALU_ADD,
    ALU_SUB,
    ALU_MUL,
    ALU_DIV
  } alu_op_t;

  typedef enum logic [2:0] {
    ERR_NONE           = 3'd0,
    ERR_WRONG_ADDRESS  = 3'd1,
    ERR_DIVIDE_BY_ZERO = 3'd2,
    ERR_WRONG_REG_NUM  = 3'd3,
    ERR_WRONG_OPCODE   = 3'd4
  } err_t;

  typedef enum logic [2:0] {
    F_LAUNCH, // first fetch after reset
    F_WORD1,
    F_WORD2,
    F_WAIT,
    F_IDLE,
    F_DONE
  } fetch_state_t;

  typedef enum logic [2:0] {
    E_IDLE,
    E_ALU_ISSUE,
    E_ALU_WB,
    E_STORE,
    E_LOAD,
    E_LOAD_END,
    E_HALT
  } exec_state_t;

  // word 1 is {opcode, count_m1, reg_base}, word 2 is imm
  typedef struct packed {
    opcode_t  opcode;
    run_len_t count_m1;
    reg_idx_t reg_base;
    word_t    imm;
    word_t    addr;     // address of word 1
  } instr_t;

  typedef struct packed {
    logic  rd;
    logic  we;
    word_t addr;
    word_t wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: core/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start,
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (start) begin
      case (op)
        ALU_ADD: result <= a + b;
        ALU_SUB: result <= a - b;
        ALU_MUL: result <= a * b; // low half of the product
        ALU_DIV: result <= a / b;
        default: result <= b;     // set
      endcase
    end
  end

  // the exec unit halts before a zero divisor can get here
  a_no_div_zero: assert property (@(posedge clk) disable iff (!rst_n)
    start && op == ALU_DIV |-> b != '0);

endmodule

`default_nettype wire

// File: core/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import cpu_pkg::*; #(
  parameter int PROGRAM_BASE = 46
) (
  input  logic     clk,
  input  logic     rst_n,
  input  instr_t   instr,
  input  logic     instr_valid,
  input  logic     done,
  output mem_req_t exec_req,
  input  word_t    mem_rdata,
  output word_t    next_pc,
  output logic     next_pc_valid,
  output logic     reg_we,
  output reg_idx_t reg_waddr,
  output word_t    reg_wdata,
  output reg_idx_t reg_raddr,
  input  word_t    reg_rdata,
  output logic     alu_start,
  output alu_op_t  alu_op,
  output word_t    alu_a,
  output word_t    alu_b,
  input  word_t    alu_result,
  output logic     halted,
  output err_t     error_code
);

  localparam word_t BASE_ADDR = word_t'(PROGRAM_BASE);

  exec_state_t state;
  run_len_t    cnt;        // position inside the register run
  logic        load_pend;  // a RAM2REG word arrives this cycle
  reg_idx_t    load_idx;
  reg_idx_t    cur_reg;
  word_t       data_addr;
  word_t       seq_pc;
  word_t       jump_tgt;
  logic [5:0]  run_end;
  logic [17:0] minus_ext;
  logic        run_last;
  err_t        dec_err;

  assign cur_reg   = instr.reg_base + {2'b00, cnt};
  assign data_addr = instr.imm + {13'd0, cnt};
  assign seq_pc    = instr.addr + 16'd2;
  assign run_end   = {1'b0, instr.reg_base} + {3'b000, instr.count_m1};
  assign minus_ext = {2'b00, instr.addr} - {1'b0, instr.imm, 1'b0};
  assign run_last  = (cnt == instr.count_m1);

  always_comb begin
    dec_err  = ERR_NONE;
    jump_tgt = instr.imm;
    case (instr.opcode)
      OP_JMP:      if (instr.imm[0]) dec_err = ERR_WRONG_ADDRESS; // targets are word pairs
      OP_JMP_PLUS: jump_tgt = instr.addr + {instr.imm[14:0], 1'b0};
      OP_JMP_MINUS: begin
        jump_tgt = minus_ext[15:0];
        if (minus_ext[17] || minus_ext[15:0] < BASE_ADDR) dec_err = ERR_WRONG_ADDRESS;
      end
      OP_RAM2REG, OP_REG2RAM: begin
        if (run_end[5])                  dec_err = ERR_WRONG_REG_NUM;
        else if (instr.imm < BASE_ADDR)  dec_err = ERR_WRONG_ADDRESS;
      end
      OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS, OP_REG_MUL: begin
        if (run_end[5]) dec_err = ERR_WRONG_REG_NUM;
      end
      OP_REG_DIV: begin
        if (run_end[5])            dec_err = ERR_WRONG_REG_NUM;
        else if (instr.imm == '0)  dec_err = ERR_DIVIDE_BY_ZERO;
      end
      default: dec_err = ERR_WRONG_OPCODE;
    endcase
  end

  always_comb begin
    case (instr.opcode)
      OP_REG_PLUS:  alu_op = ALU_ADD;
      OP_REG_MINUS: alu_op = ALU_SUB;
      OP_REG_MUL:   alu_op = ALU_MUL;
      OP_REG_DIV:   alu_op = ALU_DIV;
      default:      alu_op = ALU_SET; // NUM2REG
    endcase
  end

  assign reg_raddr = cur_reg;
  assign alu_start = (state == E_ALU_ISSUE);
  assign alu_a     = reg_rdata;
  assign alu_b     = instr.imm;

  always_comb begin
    exec_req  = '0;
    reg_we    = 1'b0;
    reg_waddr = cur_reg;
    reg_wdata = alu_result;
    case (state)
      E_STORE: begin
        exec_req.we    = 1'b1;
        exec_req.addr  = data_addr;
        exec_req.wdata = reg_rdata;
      end
      E_LOAD: begin
        exec_req.rd   = 1'b1;
        exec_req.addr = data_addr;
      end
      E_ALU_WB: reg_we = 1'b1;
      default: ;
    endcase
    if (load_pend) begin // loads and ALU write-back never overlap
      reg_we    = 1'b1;
      reg_waddr = load_idx;
      reg_wdata = mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    load_idx <= cur_reg;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= E_IDLE;
      cnt           <= '0;
      load_pend     <= 1'b0;
      next_pc       <= '0;
      next_pc_valid <= 1'b0;
      halted        <= 1'b0;
      error_code    <= ERR_NONE;
    end else begin
      next_pc_valid <= 1'b0;
      load_pend     <= (state == E_LOAD);
      case (state)
        E_IDLE: begin
          cnt <= '0;
          if (done) begin
            halted <= 1'b1;
            state  <= E_HALT;
          end else if (instr_valid) begin
            if (dec_err != ERR_NONE) begin
              halted     <= 1'b1;
              error_code <= dec_err;
              state      <= E_HALT;
            end else begin
              case (instr.opcode)
                OP_JMP, OP_JMP_PLUS, OP_JMP_MINUS: begin
                  next_pc       <= jump_tgt;
                  next_pc_valid <= 1'b1;
                end
                OP_RAM2REG: state <= E_LOAD;
                OP_REG2RAM: state <= E_STORE;
                default:    state <= E_ALU_ISSUE;
              endcase
            end
          end
        end
        E_ALU_ISSUE: state <= E_ALU_WB;
        E_ALU_WB, E_STORE: begin
          if (run_last) begin
            next_pc       <= seq_pc;
            next_pc_valid <= 1'b1;
            state         <= E_IDLE;
          end else begin
            cnt   <= cnt + 3'd1;
            state <= (state == E_ALU_WB) ? E_ALU_ISSUE : E_STORE;
          end
        end
        E_LOAD: begin
          if (run_last) state <= E_LOAD_END; // last word still in flight
          else          cnt   <= cnt + 3'd1;
        end
        E_LOAD_END: begin
          next_pc       <= seq_pc;
          next_pc_valid <= 1'b1;
          state         <= E_IDLE;
        end
        E_HALT: ;
        default: state <= E_HALT;
      endcase
    end
  end

  // no store while the data of a load is still coming back
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    exec_req.we |-> !$past(exec_req.rd));

endmodule

`default_nettype wire

// File: core/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
  parameter int PROGRAM_BASE = 46,
  parameter int PROGRAM_LAST = 62
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     next_pc_valid,
  input  word_t    next_pc,
  output mem_req_t fetch_req,
  input  word_t    mem_rdata,
  output instr_t   instr,
  output logic     instr_valid,
  output logic     done
);

  localparam word_t BASE_ADDR = word_t'(PROGRAM_BASE);
  localparam word_t LAST_ADDR = word_t'(PROGRAM_LAST);

  fetch_state_t state;
  word_t        pc;
  logic         start;
  word_t        start_pc;

  // a fetch starts once after reset and then on each pc handed back by exec
  assign start    = (state == F_LAUNCH) || (state == F_IDLE && next_pc_valid);
  assign start_pc = (state == F_LAUNCH) ? pc : next_pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= F_LAUNCH;
      pc          <= BASE_ADDR;
      fetch_req   <= '0;
      instr_valid <= 1'b0;
      done        <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      done        <= 1'b0;
      if (start) begin
        pc <= start_pc;
        if (start_pc > LAST_ADDR) begin
          done  <= 1'b1; // program ran off its end
          state <= F_DONE;
        end else begin
          fetch_req.rd   <= 1'b1;
          fetch_req.addr <= start_pc;
          state          <= F_WORD1;
        end
      end else begin
        case (state)
          F_WORD1: begin
            fetch_req.addr <= pc + 16'd1;
            state          <= F_WORD2;
          end
          F_WORD2: begin
            fetch_req.rd <= 1'b0;
            state        <= F_WAIT;
          end
          F_WAIT: begin
            instr_valid <= 1'b1;
            state       <= F_IDLE;
          end
          default: ;
        endcase
      end
    end
  end

  // word 1 lands while word 2 is on the bus
  always_ff @(posedge clk) begin
    if (state == F_WORD2) begin
      instr.opcode   <= opcode_t'(mem_rdata[15:8]);
      instr.count_m1 <= mem_rdata[7:5];
      instr.reg_base <= mem_rdata[4:0];
      instr.addr     <= pc;
    end
    if (state == F_WAIT) instr.imm <= mem_rdata;
  end

  a_valid_after_reads: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(instr_valid) |-> !fetch_req.rd && !$past(fetch_req.rd));

endmodule

`default_nettype wire

// File: core/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     we,
  input  reg_idx_t waddr,
  input  word_t    wdata,
  input  reg_idx_t raddr,
  output word_t    rdata
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata = regs[raddr]; // combinational read without write bypass

endmodule

`default_nettype wire

// File: project.f
common/cpu_pkg.sv
core/reg_file.sv
core/alu.sv
core/fetch_unit.sv
core/exec_unit.sv
src/cpu_top.sv
test/tb_clock.sv
test/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpu -Mdir obj_dir -o sim_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter int PROGRAM_BASE = 46,
  parameter int PROGRAM_LAST = 62
) (
  input  logic     clk,
  input  logic     rst_n,
  output mem_req_t mem_req,
  input  word_t    mem_rdata,
  output logic     halted,
  output err_t     error_code
);

  mem_req_t fetch_req;
  mem_req_t exec_req;
  instr_t   instr;
  logic     instr_valid;
  logic     done;
  word_t    next_pc;
  logic     next_pc_valid;
  logic     reg_we;
  reg_idx_t reg_waddr;
  word_t    reg_wdata;
  reg_idx_t reg_raddr;
  word_t    reg_rdata;
  logic     alu_start;
  alu_op_t  alu_op;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;
  logic     exec_busy;

  assign exec_busy = exec_req.rd || exec_req.we;
  assign mem_req   = exec_busy ? exec_req : fetch_req; // exec wins the port

  fetch_unit #(.PROGRAM_BASE(PROGRAM_BASE), .PROGRAM_LAST(PROGRAM_LAST)) u_fetch (
    .clk(clk), .rst_n(rst_n),
    .next_pc_valid(next_pc_valid), .next_pc(next_pc),
    .fetch_req(fetch_req), .mem_rdata(mem_rdata),
    .instr(instr), .instr_valid(instr_valid), .done(done)
  );

  exec_unit #(.PROGRAM_BASE(PROGRAM_BASE)) u_exec (
    .clk(clk), .rst_n(rst_n),
    .instr(instr), .instr_valid(instr_valid), .done(done),
    .exec_req(exec_req), .mem_rdata(mem_rdata),
    .next_pc(next_pc), .next_pc_valid(next_pc_valid),
    .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
    .reg_raddr(reg_raddr), .reg_rdata(reg_rdata),
    .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
    .alu_result(alu_result),
    .halted(halted), .error_code(error_code)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
    .raddr(reg_raddr), .rdata(reg_rdata)
  );

  alu u_alu (
    .clk(clk), .rst_n(rst_n),
    .start(alu_start), .op(alu_op), .a(alu_a), .b(alu_b),
    .result(alu_result)
  );

  // fetch only runs between next_pc_valid and instr_valid, while exec waits
  a_port_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    exec_busy |-> !(fetch_req.rd || fetch_req.we));

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);

  logic clk_q   = 1'b0;
  logic rst_q   = 1'b0;
  int   rst_cnt = RESET_CYCLES;

  assign clk   = clk_q;
  assign rst_n = rst_q;

  initial begin
    forever #(PERIOD_NS / 2) clk_q = ~clk_q;
  end

  always @(negedge clk_q) begin
    if (reset_req) begin
      rst_q   <= 1'b0;
      rst_cnt <= RESET_CYCLES;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
      if (rst_cnt == 1) rst_q <= 1'b1; // release after the last low cycle
    end
  end

endmodule

`default_nettype wire

// File: test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int BASE    = 46;
  localparam int LAST    = 62;
  localparam int TIMEOUT = 2000;

  logic     clk;
  logic     rst_n;
  logic     reset_req = 1'b0;
  logic     load_req  = 1'b0;
  mem_req_t mem_req;
  word_t    mem_rdata = 16'h0000;
  logic     halted;
  err_t     error_code;

  word_t mem [256];
  word_t prog_img [256];  // next program, copied into mem on load_req
  word_t ref_mem [256];
  word_t wr_addr [$];
  word_t wr_data [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  logic  rd_pend = 1'b0;
  word_t rd_addr = 16'h0000;
  logic  ref_overrun;
  word_t lfsr_state = 16'd13203;

  tb_clock u_clk (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

  cpu_top u_dut (
    .clk(clk), .rst_n(rst_n),
    .mem_req(mem_req), .mem_rdata(mem_rdata),
    .halted(halted), .error_code(error_code)
  );

  // memory model with one cycle of read latency
  always @(negedge clk) begin
    if (load_req) begin
      for (int i = 0; i < 256; i++) mem[i] = prog_img[i];
      wr_addr.delete();
      wr_data.delete();
      rd_pend = 1'b0;
    end else begin
      if (rd_pend) mem_rdata = mem[rd_addr[7:0]];
      rd_pend = mem_req.rd;
      rd_addr = mem_req.addr;
      if (mem_req.we) begin
        mem[mem_req.addr[7:0]] = mem_req.wdata;
        wr_addr.push_back(mem_req.addr);
        wr_data.push_back(mem_req.wdata);
      end
    end
  end

  function automatic word_t rand_bits(input int n);
    word_t v;
    logic  lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
      v = {v[14:0], lsb};
    end
    return v;
  endfunction

  // interprets ref_mem from the program base and fills the expected write list
  function automatic err_t run_reference();
    word_t     regs [32];
    word_t     pc;
    word_t     w1;
    word_t     imm;
    word_t     da;
    logic [7:0] op;
    int        m1;
    int        base;
    int        minus;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    exp_addr.delete();
    exp_data.delete();
    ref_overrun = 1'b0;
    pc = word_t'(BASE);
    for (int step = 0; step < 200; step++) begin
      if (int'(pc) > LAST) return ERR_NONE;
      w1   = ref_mem[pc[7:0]];
      imm  = ref_mem[8'(pc[7:0] + 8'd1)];
      op   = w1[15:8];
      m1   = int'(w1[7:5]);
      base = int'(w1[4:0]);
      case (op)
        OP_JMP: begin
          if (imm[0]) return ERR_WRONG_ADDRESS;
          pc = imm;
        end
        OP_JMP_PLUS: pc = word_t'(int'(pc) + 2 * int'(imm));
        OP_JMP_MINUS: begin
          minus = int'(pc) - 2 * int'(imm);
          if (minus < BASE) return ERR_WRONG_ADDRESS;
          pc = word_t'(minus);
        end
        OP_RAM2REG, OP_REG2RAM: begin
          if (base + m1 > 31) return ERR_WRONG_REG_NUM;
          if (int'(imm) < BASE) return ERR_WRONG_ADDRESS;
          for (int i = 0; i <= m1; i++) begin
            da = imm + word_t'(i);
            if (op == OP_RAM2REG) begin
              regs[base + i] = ref_mem[da[7:0]];
            end else begin
              ref_mem[da[7:0]] = regs[base + i];
              exp_addr.push_back(da);
              exp_data.push_back(regs[base + i]);
            end
          end
          pc = pc + 16'd2;
        end
        OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS, OP_REG_MUL, OP_REG_DIV: begin
          if (base + m1 > 31) return ERR_WRONG_REG_NUM;
          if (op == OP_REG_DIV && imm == '0) return ERR_DIVIDE_BY_ZERO;
          for (int i = base; i <= base + m1; i++) begin
            case (op)
              OP_NUM2REG:   regs[i] = imm;
              OP_REG_PLUS:  regs[i] = regs[i] + imm;
              OP_REG_MINUS: regs[i] = regs[i] - imm;
              OP_REG_MUL:   regs[i] = regs[i] * imm; // low 16 bits
              default:      regs[i] = regs[i] / imm;
            endcase
          end
          pc = pc + 16'd2;
        end
        default: return ERR_WRONG_OPCODE;
      endcase
    end
    ref_overrun = 1'b1;
    return ERR_NONE;
  endfunction

  task automatic stop_with_message(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_err(input string name, input err_t exp, input err_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic set_instr(input int at, input logic [7:0] op, input int m1, input int base,
                           input word_t imm);
    prog_img[at]     = {op, 3'(m1), 5'(base)};
    prog_img[at + 1] = imm;
  endtask

  // fill pattern everywhere, then every program slot jumps past the end
  task automatic clear_image();
    for (int i = 0; i < 256; i++) prog_img[i] = word_t'(i * 263) ^ 16'h9C3A;
    for (int a = BASE; a <= LAST; a += 2) set_instr(a, OP_JMP, 0, 0, 16'd64);
  endtask

  task automatic run_test(input string name);
    err_t exp_err;
    int   cycles;
    for (int i = 0; i < 256; i++) ref_mem[i] = prog_img[i];
    exp_err = run_reference();
    if (ref_overrun) stop_with_message({"reference did not end for test ", name});
    @(posedge clk);
    load_req = 1'b1;
    @(posedge clk);
    load_req  = 1'b0;
    reset_req = 1'b1;
    @(posedge clk);
    reset_req = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) stop_with_message({"reset never completed in test ", name});
    end while (!rst_n || halted);
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) stop_with_message({"cpu never halted in test ", name});
    end
    repeat (4) @(negedge clk); // late writes would show up here
    check_err({name, " error code"}, exp_err, error_code);
    check_word({name, " write count"}, word_t'(exp_addr.size()), word_t'(wr_addr.size()));
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_word({name, " write address"}, exp_addr[i], wr_addr[i]);
      check_word({name, " write data"}, exp_data[i], wr_data[i]);
    end
  endtask

  initial begin
    clear_image();
    set_instr(46, OP_NUM2REG, 3, 2, rand_bits(16));
    set_instr(48, OP_REG_PLUS, 3, 2, rand_bits(16));
    set_instr(50, OP_REG_MUL, 2, 3, rand_bits(8));
    set_instr(52, OP_REG_MINUS, 3, 2, rand_bits(16));
    set_instr(54, OP_REG_DIV, 3, 2, rand_bits(4) + 16'd1);
    set_instr(56, OP_NUM2REG, 1, 7, rand_bits(16));
    set_instr(58, OP_REG2RAM, 6, 2, 16'd120);
    set_instr(60, OP_REG2RAM, 7, 24, 16'd130);
    run_test("arith");

    clear_image();
    set_instr(46, OP_RAM2REG, 7, 10, 16'd140);
    set_instr(48, OP_RAM2REG, 2, 29, 16'd150);
    set_instr(50, OP_REG2RAM, 7, 10, 16'd160);
    set_instr(52, OP_REG2RAM, 2, 29, 16'd170);
    run_test("block move");

    clear_image();
    set_instr(46, OP_JMP_PLUS, 0, 0, 16'd3);  // over the loop body
    set_instr(48, OP_REG_PLUS, 0, 1, 16'd5);
    set_instr(50, OP_JMP, 0, 0, 16'd58);
    set_instr(52, OP_NUM2REG, 0, 1, rand_bits(16));
    set_instr(54, OP_REG2RAM, 0, 1, 16'd200);
    set_instr(56, OP_JMP_MINUS, 0, 0, 16'd4); // back to 48
    set_instr(58, OP_REG2RAM, 0, 1, 16'd201);
    set_instr(60, OP_JMP_PLUS, 0, 0, 16'd2);
    set_instr(62, OP_REG2RAM, 0, 1, 16'd203);
    run_test("jumps");

    clear_image();
    set_instr(46, OP_NUM2REG, 1, 0, rand_bits(16));
    set_instr(48, OP_REG2RAM, 1, 0, 16'd210);
    set_instr(50, OP_REG_DIV, 1, 0, 16'd0);
    set_instr(52, OP_REG2RAM, 1, 0, 16'd212);
    run_test("divide by zero");

    clear_image();
    set_instr(46, OP_NUM2REG, 7, 28, 16'd9);
    run_test("register range");

    clear_image();
    set_instr(46, OP_NUM2REG, 0, 3, 16'd77);
    set_instr(48, OP_REG2RAM, 0, 3, 16'd40);
    run_test("low data address");

    clear_image();
    set_instr(46, OP_JMP, 0, 0, 16'd51);
    run_test("odd jump");

    clear_image();
    set_instr(46, OP_NUM2REG, 0, 4, 16'd1);
    set_instr(48, 8'h33, 0, 0, 16'd0);
    run_test("bad opcode");

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
